/* files.f */
+incdir+verilog
verilog/isa_pkg.sv
verilog/fe_pkg.sv
verilog/next_pc_predictor.sv
verilog/fetch_unit.sv
verilog/inst_packer.sv
verilog/inst_queue.sv
verilog/frontend.sv
sim/frontend_asserts.sv
sim/frontend_tb.sv

/* run.sh */
#!/bin/sh
# build and run the frontend testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module frontend_tb \
    -f files.f -o frontend_sim \
    && ./obj_dir/frontend_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q '^>>> PASS$' sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* sim/frontend_asserts.sv */
`timescale 1ns/1ps

module frontend_asserts (
    input logic       clk,
    input logic       rst_i,
    input logic       cyc_i,
    input logic       stb_i,
    input logic       ack_i,
    input logic [1:0] valid_i,
    input logic       wr_en_i,
    input logic       room_i,
    input logic       flush_i
);
    int fail_cnt = 0;

    assert property (@(posedge clk) disable iff (rst_i) stb_i |-> cyc_i)
    else begin
        $error("wishbone stb high without cyc");
        fail_cnt++;
    end

    // classic cycle may not be abandoned before ack
    assert property (@(posedge clk) disable iff (rst_i) cyc_i && !ack_i |=> cyc_i)
    else begin
        $error("wishbone cyc dropped before ack");
        fail_cnt++;
    end

    assert property (@(posedge clk) disable iff (rst_i) valid_i[1] |-> valid_i[0])
    else begin
        $error("out_valid slot 1 without slot 0");
        fail_cnt++;
    end

    assert property (@(posedge clk) disable iff (rst_i) wr_en_i && !flush_i |-> room_i)
    else begin
        $error("queue written without room");
        fail_cnt++;
    end

endmodule

bind fetch_unit frontend_asserts u_fetch_chk (
    .clk,
    .rst_i,
    .cyc_i   (wb_cyc_o),
    .stb_i   (wb_stb_o),
    .ack_i   (wb_ack_i),
    .valid_i (2'b00),
    .wr_en_i (1'b0),
    .room_i  (1'b1),
    .flush_i
);

bind inst_queue frontend_asserts u_queue_chk (
    .clk,
    .rst_i,
    .cyc_i   (1'b0),
    .stb_i   (1'b0),
    .ack_i   (1'b0),
    .valid_i (out_valid_o),
    .wr_en_i (wr_en_i),
    .room_i  (wr_room_o),
    .flush_i
);

/* sim/frontend_tb.sv */
`timescale 1ns/1ps
`include "fe_cfg.svh"

module frontend_tb;
    localparam int NUM_TESTS = 6;
    localparam int BTB_IW = $clog2(`FE_BTB_ENTRIES);

    logic                      clk;
    logic                      rst_i;
    logic                      wb_cyc_o;
    logic                      wb_stb_o;
    fe_pkg::bus_adr_t          wb_adr_o;
    logic [63:0]               wb_dat_i;
    logic                      wb_ack_i;
    logic                      flush_i;
    fe_pkg::pc_t               flush_pc_i;
    logic                      upd_valid_i;
    fe_pkg::pc_t               upd_pc_i;
    fe_pkg::pc_t               upd_target_i;
    logic                      upd_taken_i;
    logic [1:0]                out_valid_o;
    fe_pkg::pc_t [1:0]         out_pc_o;
    isa_pkg::inst_word_t [1:0] out_word_o;
    isa_pkg::reg_idx_t [1:0]   out_rs0_o;
    isa_pkg::reg_idx_t [1:0]   out_rs1_o;
    isa_pkg::reg_idx_t [1:0]   out_rd_o;
    logic [1:0]                out_pred_taken_o;
    fe_pkg::num_t              deq_num_i;

    integer     seed = 24910;
    int         errors;
    int         checks;
    int         popped;
    int         err_mark;
    int         pop_mark;
    int         wait_left;
    int         taken_seen;
    logic       slow_bus;
    logic [5:0] cls_seen;

    // reference model with expected records and its own btb state
    fe_pkg::pc_t         model_pc;
    fe_pkg::pc_t         exp_pc[$];
    isa_pkg::inst_word_t exp_word[$];
    logic                exp_taken[$];
    logic                m_valid  [`FE_BTB_ENTRIES];
    logic [31:0]         m_tag    [`FE_BTB_ENTRIES];
    logic                m_slot   [`FE_BTB_ENTRIES];
    fe_pkg::pc_t         m_target [`FE_BTB_ENTRIES];

    frontend u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        repeat (NUM_TESTS * 2000) @(posedge clk);
        $display("watchdog expired after %0d cycles, tests did not finish", NUM_TESTS * 2000);
        $display(">>> FAIL");
        $finish;
    end

    // instruction pair hashed over all bits of the bus word address
    function automatic logic [63:0] mem_pair(input fe_pkg::bus_adr_t adr);
        logic [31:0] h0;
        logic [31:0] h1;
        h0 = {3'b000, adr} * 32'h9e37_79b1;
        h0 = h0 ^ (h0 >> 15) ^ {adr, 3'b101};
        h1 = ({3'b000, adr} ^ 32'h5bd1_e995) * 32'h85eb_ca6b;
        h1 = h1 ^ (h1 >> 13);
        return {h1, h0};
    endfunction

    // memory acks after 0..3 wait cycles plus 8 more when slow_bus is set
    always @(posedge clk) begin
        if (rst_i) begin
            wb_ack_i  <= 1'b0;
            wait_left <= 0;
        end else if (wb_ack_i) begin
            wb_ack_i  <= 1'b0;
            wait_left <= ($random(seed) & 3) + (slow_bus ? 8 : 0);
        end else if (wb_cyc_o && wb_stb_o) begin
            if (wait_left == 0) begin
                wb_ack_i <= 1'b1;
                wb_dat_i <= mem_pair(wb_adr_o);
            end else begin
                wait_left <= wait_left - 1;
            end
        end
    end

    function automatic fe_pkg::num_t rand_deq();
        return fe_pkg::num_t'($unsigned($random(seed)) % 3);
    endfunction

    function automatic fe_pkg::pc_t near_pc(input logic odd);
        return `FE_RESET_PC + ($unsigned($random(seed)) % 512) * 8 + (odd ? 4 : 0);
    endfunction

    // register use by the class in bits 31:28
    task automatic expect_regs(input logic [31:0] w, output logic [4:0] rs0,
                               output logic [4:0] rs1, output logic [4:0] rd);
        rs0 = 5'd0;
        rs1 = 5'd0;
        rd  = 5'd0;
        case (w[31:28])
            4'd0: begin
                rs0 = w[14:10];
                rs1 = w[9:5];
                rd  = w[4:0];
            end
            4'd1: begin
                rs1 = w[9:5];
                rd  = w[4:0];
            end
            4'd2: begin
                rs0 = w[4:0];
                rs1 = w[9:5];
            end
            4'd3: rd = 5'd1;
            4'd4: rd = w[4:0];
            default: rd = 5'd0;
        endcase
    endtask

    task automatic model_pair();
        logic [BTB_IW-1:0] idx;
        logic              taken;
        logic [1:0]        v;
        logic [63:0]       d;
        fe_pkg::pc_t       base;
        base  = {model_pc[31:3], 3'b000};
        idx   = model_pc[BTB_IW+2:3];
        // a branch counts only when its own slot is fetched
        taken = m_valid[idx] && m_tag[idx] == (model_pc >> (BTB_IW + 3))
                && (m_slot[idx] || !model_pc[2]);
        v[0]  = !model_pc[2];
        v[1]  = !(taken && !m_slot[idx]);
        d     = mem_pair(model_pc[31:3]);
        if (v[0]) begin
            exp_pc.push_back(base);
            exp_word.push_back(d[31:0]);
            exp_taken.push_back(taken && !v[1]);
        end
        if (v[1]) begin
            exp_pc.push_back(base + 4);
            exp_word.push_back(d[63:32]);
            exp_taken.push_back(taken);
        end
        model_pc = taken ? m_target[idx] : base + 8;
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("** Error: %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // records shown this cycle and popped at the next edge
    task automatic check_pops();
        int          shown;
        int          pops;
        logic [4:0]  rs0;
        logic [4:0]  rs1;
        logic [4:0]  rd;
        logic [31:0] w;
        shown = out_valid_o[1] ? 2 : (out_valid_o[0] ? 1 : 0);
        pops  = int'(deq_num_i) < shown ? int'(deq_num_i) : shown;
        for (int i = 0; i < pops; i++) begin
            while (exp_pc.size() == 0) begin
                model_pair();
            end
            w = exp_word[0];
            expect_regs(w, rs0, rs1, rd);
            check_val($sformatf("out_pc_o[%0d]", i), out_pc_o[i], exp_pc[0]);
            check_val($sformatf("out_word_o[%0d]", i), out_word_o[i], w);
            check_val($sformatf("out_rs0_o[%0d]", i), out_rs0_o[i], rs0);
            check_val($sformatf("out_rs1_o[%0d]", i), out_rs1_o[i], rs1);
            check_val($sformatf("out_rd_o[%0d]", i), out_rd_o[i], rd);
            check_val($sformatf("out_pred_taken_o[%0d]", i), out_pred_taken_o[i], exp_taken[0]);
            cls_seen[w[31:28] <= 4'd4 ? int'(w[31:28]) : 5] = 1'b1;
            taken_seen += out_pred_taken_o[i];
            void'(exp_pc.pop_front());
            void'(exp_word.pop_front());
            void'(exp_taken.pop_front());
            popped++;
        end
    endtask

    task automatic tick(input fe_pkg::num_t deq);
        @(posedge clk);
        deq_num_i   <= deq;
        flush_i     <= 1'b0;
        upd_valid_i <= 1'b0;
        @(negedge clk);
        check_pops();
    endtask

    // flush with an optional btb update in the same cycle
    task automatic redirect(input fe_pkg::pc_t pc, input logic train, input fe_pkg::pc_t upc,
                            input fe_pkg::pc_t tgt, input logic tk);
        logic [BTB_IW-1:0] idx;
        @(posedge clk);
        deq_num_i    <= 2'd0;
        flush_i      <= 1'b1;
        flush_pc_i   <= pc;
        upd_valid_i  <= train;
        upd_pc_i     <= upc;
        upd_target_i <= tgt;
        upd_taken_i  <= tk;
        @(negedge clk);
        exp_pc.delete();
        exp_word.delete();
        exp_taken.delete();
        model_pc = pc;
        idx = upc[BTB_IW+2:3];
        if (train && tk) begin
            m_valid[idx]  = 1'b1;
            m_tag[idx]    = upc >> (BTB_IW + 3);
            m_slot[idx]   = upc[2];
            m_target[idx] = tgt;
        end else if (train && m_tag[idx] == (upc >> (BTB_IW + 3))) begin
            m_valid[idx] = 1'b0;
        end
    endtask

    task automatic end_test(input int num, input string name);
        checks++;
        assert (popped > pop_mark) else begin
            $display("test %0d popped no records", num);
            errors++;
        end
        $display("test %0d %s: %0d records, %0d errors", num, name,
                 popped - pop_mark, errors - err_mark);
        err_mark = errors;
        pop_mark = popped;
    endtask

    initial begin
        fe_pkg::pc_t p;
        fe_pkg::pc_t t;
        int          n;
        rst_i        = 1'b1;
        flush_i      = 1'b0;
        flush_pc_i   = '0;
        upd_valid_i  = 1'b0;
        upd_pc_i     = '0;
        upd_target_i = '0;
        upd_taken_i  = 1'b0;
        deq_num_i    = '0;
        wb_ack_i     = 1'b0;
        wb_dat_i     = '0;
        errors       = 0;
        checks       = 0;
        popped       = 0;
        err_mark     = 0;
        pop_mark     = 0;
        taken_seen   = 0;
        slow_bus     = 1'b0;
        cls_seen     = '0;
        model_pc     = `FE_RESET_PC;
        for (int i = 0; i < `FE_BTB_ENTRIES; i++) begin
            m_valid[i] = 1'b0;
            m_tag[i]   = '0;
        end
        repeat (2) @(posedge clk);
        rst_i <= 1'b0;
        @(negedge clk);
        check_val("wb_cyc_o", wb_cyc_o, 0);
        check_val("wb_stb_o", wb_stb_o, 0);
        check_val("out_valid_o", out_valid_o, 0);

        repeat (300) tick(rand_deq());
        end_test(1, "sequential fetch");

        cls_seen = '0;
        repeat (600) tick(rand_deq());
        checks++;
        assert (cls_seen == 6'h3f) else begin
            $display("not every register class showed up in the popped records");
            errors++;
        end
        end_test(2, "register extraction");

        taken_seen = 0;
        for (int k = 0; k < 4; k++) begin
            p = near_pc(k[0]);
            t = near_pc(k[1]);
            redirect({p[31:3], 3'b000}, 1'b1, p, t, 1'b1);
            repeat (120) tick(rand_deq());
        end
        // a not-taken update removes the last branch
        redirect({p[31:3], 3'b000}, 1'b1, p, t, 1'b0);
        repeat (120) tick(rand_deq());
        checks++;
        assert (taken_seen > 0) else begin
            $display("no popped record was marked predicted taken");
            errors++;
        end
        end_test(3, "prediction");

        for (int k = 0; k < 4; k++) begin
            repeat (30) tick(2'd0);
            redirect(near_pc(1'b1), 1'b0, '0, '0, 1'b0);
            tick(rand_deq());
            check_val("out_valid_o", out_valid_o, 0);
            repeat (80) tick(rand_deq());
        end
        end_test(4, "unaligned redirect");

        for (int k = 0; k < 3; k++) begin
            repeat (60) tick(2'd0);
            check_val("out_valid_o", out_valid_o, 2'b11);
            repeat (100) tick(rand_deq());
        end
        end_test(5, "back-pressure");

        slow_bus = 1'b1;
        for (int k = 0; k < 5; k++) begin
            repeat (20) tick(rand_deq());
            n = 0;
            while (!(wb_cyc_o && !wb_ack_i) && n < 50) begin
                tick(rand_deq());
                n++;
            end
            checks++;
            assert (n < 50) else begin
                $display("no bus cycle started within 50 cycles");
                errors++;
            end
            redirect(near_pc(k[0]), 1'b0, '0, '0, 1'b0);
            repeat (60) tick(rand_deq());
        end
        slow_bus = 1'b0;
        repeat (100) tick(rand_deq());
        end_test(6, "flush during slow bus cycle");

        n = u_dut.u_fetch.u_fetch_chk.fail_cnt + u_dut.u_queue.u_queue_chk.fail_cnt;
        errors += n;
        $display("tests %0d, checks %0d, records %0d, assertion failures %0d, errors %0d",
                 NUM_TESTS, checks, popped, n, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* verilog/fe_cfg.svh */
`ifndef FE_CFG_SVH
`define FE_CFG_SVH

// first pair fetched after reset, must be 8-byte aligned
`define FE_RESET_PC 32'h0000_1000

// instruction queue entries, power of two
`define FE_QUEUE_DEPTH 8

// direct-mapped btb entries, power of two
`define FE_BTB_ENTRIES 8

`endif

/* verilog/fe_pkg.sv */
`include "fe_cfg.svh"

package fe_pkg;

    typedef logic [31:0] pc_t;

    // wishbone word address of an instruction pair
    typedef logic [28:0] bus_adr_t;

    // records moved per cycle, 0..2
    typedef logic [1:0] num_t;

    localparam int QUEUE_AW = $clog2(`FE_QUEUE_DEPTH);

    typedef logic [QUEUE_AW-1:0] qidx_t;
    typedef logic [QUEUE_AW:0] qcount_t;

    typedef enum logic [1:0] {
        IDLE,
        BUS,
        DISCARD
    } fetch_state_e;

endpackage

/* verilog/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
    input  logic                          clk,
    input  logic                          rst_i,
    input  fe_pkg::pc_t                   fetch_pc_i,
    input  logic                          wr_room_i,
    input  logic                          flush_i,
    input  logic [63:0]                   wb_dat_i,
    input  logic                          wb_ack_i,
    output logic                          pc_take_o,
    output logic                          wb_cyc_o,
    output logic                          wb_stb_o,
    output fe_pkg::bus_adr_t              wb_adr_o,
    output logic                          words_valid_o,
    output isa_pkg::inst_word_t [1:0]     words_o
);
    fe_pkg::fetch_state_e state;
    fe_pkg::fetch_state_e state_nx;

    // wait out the cycle a pair is written, its entries are not yet counted
    assign pc_take_o = state == fe_pkg::IDLE && wr_room_i && !flush_i && !words_valid_o;

    // classic cycle, stb follows cyc for the whole read
    assign wb_cyc_o = state != fe_pkg::IDLE;
    assign wb_stb_o = wb_cyc_o;

    always_comb begin
        state_nx = state;
        case (state)
            fe_pkg::IDLE: begin
                if (pc_take_o) begin
                    state_nx = fe_pkg::BUS;
                end
            end
            fe_pkg::BUS: begin
                if (wb_ack_i) begin
                    state_nx = fe_pkg::IDLE;
                end else if (flush_i) begin
                    state_nx = fe_pkg::DISCARD;
                end
            end
            fe_pkg::DISCARD: begin
                if (wb_ack_i) begin
                    state_nx = fe_pkg::IDLE;
                end
            end
            default: begin
                state_nx = fe_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state         <= fe_pkg::IDLE;
            words_valid_o <= 1'b0;
        end else begin
            state         <= state_nx;
            // a flush on the ack cycle drops the pair as well
            words_valid_o <= state == fe_pkg::BUS && wb_ack_i && !flush_i;
        end
    end

    always_ff @(posedge clk) begin
        if (pc_take_o) begin
            wb_adr_o <= fetch_pc_i[31:3];
        end
        if (state == fe_pkg::BUS && wb_ack_i) begin
            words_o <= wb_dat_i;
        end
    end

endmodule

/* verilog/frontend.sv */
`timescale 1ns/1ps

module frontend (
    input  logic                          clk,
    input  logic                          rst_i,
    output logic                          wb_cyc_o,
    output logic                          wb_stb_o,
    output fe_pkg::bus_adr_t              wb_adr_o,
    input  logic [63:0]                   wb_dat_i,
    input  logic                          wb_ack_i,
    input  logic                          flush_i,
    input  fe_pkg::pc_t                   flush_pc_i,
    input  logic                          upd_valid_i,
    input  fe_pkg::pc_t                   upd_pc_i,
    input  fe_pkg::pc_t                   upd_target_i,
    input  logic                          upd_taken_i,
    output logic [1:0]                    out_valid_o,
    output fe_pkg::pc_t [1:0]             out_pc_o,
    output isa_pkg::inst_word_t [1:0]     out_word_o,
    output isa_pkg::reg_idx_t [1:0]       out_rs0_o,
    output isa_pkg::reg_idx_t [1:0]       out_rs1_o,
    output isa_pkg::reg_idx_t [1:0]       out_rd_o,
    output logic [1:0]                    out_pred_taken_o,
    input  fe_pkg::num_t                  deq_num_i
);
    fe_pkg::pc_t               fetch_pc;
    fe_pkg::pc_t               pred_pc;
    logic [1:0]                pred_mask;
    logic                      pred_taken;
    logic                      pc_take;
    logic                      wr_room;
    logic                      words_valid;
    isa_pkg::inst_word_t [1:0] words;
    logic                      wr_en;
    fe_pkg::num_t              wr_num;
    fe_pkg::pc_t [1:0]         wr_pc;
    isa_pkg::inst_word_t [1:0] wr_word;
    isa_pkg::reg_idx_t [1:0]   wr_rs0;
    isa_pkg::reg_idx_t [1:0]   wr_rs1;
    isa_pkg::reg_idx_t [1:0]   wr_rd;
    logic [1:0]                wr_taken;

    // target has no consumer until a decode stage checks it
    next_pc_predictor u_predictor (
        .clk,
        .rst_i,
        .pc_take_i     (pc_take),
        .flush_i,
        .flush_pc_i,
        .upd_valid_i,
        .upd_pc_i,
        .upd_target_i,
        .upd_taken_i,
        .fetch_pc_o    (fetch_pc),
        .pred_pc_o     (pred_pc),
        .pred_mask_o   (pred_mask),
        .pred_taken_o  (pred_taken),
        .pred_target_o ()
    );

    fetch_unit u_fetch (
        .clk,
        .rst_i,
        .fetch_pc_i    (fetch_pc),
        .wr_room_i     (wr_room),
        .flush_i,
        .wb_dat_i,
        .wb_ack_i,
        .pc_take_o     (pc_take),
        .wb_cyc_o,
        .wb_stb_o,
        .wb_adr_o,
        .words_valid_o (words_valid),
        .words_o       (words)
    );

    inst_packer u_packer (
        .words_valid_i (words_valid),
        .words_i       (words),
        .pred_pc_i     (pred_pc),
        .pred_mask_i   (pred_mask),
        .pred_taken_i  (pred_taken),
        .wr_en_o       (wr_en),
        .wr_num_o      (wr_num),
        .wr_pc_o       (wr_pc),
        .wr_word_o     (wr_word),
        .wr_rs0_o      (wr_rs0),
        .wr_rs1_o      (wr_rs1),
        .wr_rd_o       (wr_rd),
        .wr_taken_o    (wr_taken)
    );

    inst_queue u_queue (
        .clk,
        .rst_i,
        .flush_i,
        .wr_en_i       (wr_en),
        .wr_num_i      (wr_num),
        .wr_pc_i       (wr_pc),
        .wr_word_i     (wr_word),
        .wr_rs0_i      (wr_rs0),
        .wr_rs1_i      (wr_rs1),
        .wr_rd_i       (wr_rd),
        .wr_taken_i    (wr_taken),
        .deq_num_i,
        .wr_room_o     (wr_room),
        .out_valid_o,
        .out_pc_o,
        .out_word_o,
        .out_rs0_o,
        .out_rs1_o,
        .out_rd_o,
        .out_pred_taken_o
    );

endmodule

/* verilog/inst_packer.sv */
`timescale 1ns/1ps

module inst_packer (
    input  logic                          words_valid_i,
    input  isa_pkg::inst_word_t [1:0]     words_i,
    input  fe_pkg::pc_t                   pred_pc_i,
    input  logic [1:0]                    pred_mask_i,
    input  logic                          pred_taken_i,
    output logic                          wr_en_o,
    output fe_pkg::num_t                  wr_num_o,
    output fe_pkg::pc_t [1:0]             wr_pc_o,
    output isa_pkg::inst_word_t [1:0]     wr_word_o,
    output isa_pkg::reg_idx_t [1:0]       wr_rs0_o,
    output isa_pkg::reg_idx_t [1:0]       wr_rs1_o,
    output isa_pkg::reg_idx_t [1:0]       wr_rd_o,
    output logic [1:0]                    wr_taken_o
);
    // packed as {rs0, rs1, rd}
    function automatic logic [14:0] reg_info(input isa_pkg::inst_word_t w);
        isa_pkg::reg_class_e cls;
        logic [14:0]         ret;
        cls = w[31:28] <= 4'd4 ? isa_pkg::reg_class_e'(w[31:28]) : isa_pkg::CLS_I;
        case (cls)
            isa_pkg::CLS_RRW: ret = {w[14:10], w[9:5], w[4:0]};
            isa_pkg::CLS_RW:  ret = {5'd0, w[9:5], w[4:0]};
            isa_pkg::CLS_RR:  ret = {w[4:0], w[9:5], 5'd0};
            isa_pkg::CLS_BL:  ret = {10'd0, isa_pkg::LINK_REG};
            isa_pkg::CLS_W:   ret = {10'd0, w[4:0]};
            default:          ret = '0;
        endcase
        return ret;
    endfunction

    logic [1:0]          slot_v;
    isa_pkg::inst_word_t first_word;
    logic [14:0]         info0;
    logic [14:0]         info1;

    assign slot_v   = pred_mask_i & {2{words_valid_i}};
    assign wr_en_o  = |slot_v;
    assign wr_num_o = {slot_v[0] & slot_v[1], slot_v[0] ^ slot_v[1]};

    // output slot 0 takes the first valid word of the pair
    assign first_word = slot_v[0] ? words_i[0] : words_i[1];
    assign wr_word_o  = {words_i[1], first_word};
    assign wr_pc_o[0] = {pred_pc_i[31:3], !slot_v[0], 2'b00};
    assign wr_pc_o[1] = {pred_pc_i[31:3], 3'b100};

    assign info0 = reg_info(first_word);
    assign info1 = reg_info(words_i[1]);
    assign wr_rs0_o = {info1[14:10], info0[14:10]};
    assign wr_rs1_o = {info1[9:5], info0[9:5]};
    assign wr_rd_o  = {info1[4:0], info0[4:0]};

    // the predicted branch ends the pair
    assign wr_taken_o = {pred_taken_i && wr_num_o == 2'd2, pred_taken_i && wr_num_o == 2'd1};

endmodule

/* verilog/inst_queue.sv */
`timescale 1ns/1ps
`include "fe_cfg.svh"

module inst_queue (
    input  logic                          clk,
    input  logic                          rst_i,
    input  logic                          flush_i,
    input  logic                          wr_en_i,
    input  fe_pkg::num_t                  wr_num_i,
    input  fe_pkg::pc_t [1:0]             wr_pc_i,
    input  isa_pkg::inst_word_t [1:0]     wr_word_i,
    input  isa_pkg::reg_idx_t [1:0]       wr_rs0_i,
    input  isa_pkg::reg_idx_t [1:0]       wr_rs1_i,
    input  isa_pkg::reg_idx_t [1:0]       wr_rd_i,
    input  logic [1:0]                    wr_taken_i,
    input  fe_pkg::num_t                  deq_num_i,
    output logic                          wr_room_o,
    output logic [1:0]                    out_valid_o,
    output fe_pkg::pc_t [1:0]             out_pc_o,
    output isa_pkg::inst_word_t [1:0]     out_word_o,
    output isa_pkg::reg_idx_t [1:0]       out_rs0_o,
    output isa_pkg::reg_idx_t [1:0]       out_rs1_o,
    output isa_pkg::reg_idx_t [1:0]       out_rd_o,
    output logic [1:0]                    out_pred_taken_o
);
    localparam int DEPTH = `FE_QUEUE_DEPTH;

    fe_pkg::pc_t         pc_mem    [DEPTH];
    isa_pkg::inst_word_t word_mem  [DEPTH];
    isa_pkg::reg_idx_t   rs0_mem   [DEPTH];
    isa_pkg::reg_idx_t   rs1_mem   [DEPTH];
    isa_pkg::reg_idx_t   rd_mem    [DEPTH];
    logic                taken_mem [DEPTH];

    fe_pkg::qidx_t   head;
    fe_pkg::qidx_t   head_nx;
    fe_pkg::qidx_t   tail;
    fe_pkg::qidx_t   tail_nx;
    fe_pkg::qcount_t count;
    fe_pkg::num_t    wr_n;
    fe_pkg::num_t    avail;
    fe_pkg::num_t    deq_n;

    assign head_nx = head + 1'b1;
    assign tail_nx = tail + 1'b1;
    assign wr_n    = wr_en_i ? wr_num_i : 2'd0;

    assign out_valid_o = {count >= 2, count != 0};
    assign avail       = {out_valid_o[1], out_valid_o[0] & !out_valid_o[1]};
    // never pop more than is shown
    assign deq_n       = deq_num_i > avail ? avail : deq_num_i;
    assign wr_room_o   = count <= fe_pkg::qcount_t'(DEPTH - 2);

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head + deq_n;
            tail  <= tail + wr_n;
            count <= count + wr_n - deq_n;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_n != 2'd0 && !flush_i) begin
            pc_mem[tail]    <= wr_pc_i[0];
            word_mem[tail]  <= wr_word_i[0];
            rs0_mem[tail]   <= wr_rs0_i[0];
            rs1_mem[tail]   <= wr_rs1_i[0];
            rd_mem[tail]    <= wr_rd_i[0];
            taken_mem[tail] <= wr_taken_i[0];
            if (wr_n == 2'd2) begin
                pc_mem[tail_nx]    <= wr_pc_i[1];
                word_mem[tail_nx]  <= wr_word_i[1];
                rs0_mem[tail_nx]   <= wr_rs0_i[1];
                rs1_mem[tail_nx]   <= wr_rs1_i[1];
                rd_mem[tail_nx]    <= wr_rd_i[1];
                taken_mem[tail_nx] <= wr_taken_i[1];
            end
        end
    end

    // read side straight from head
    assign out_pc_o         = {pc_mem[head_nx], pc_mem[head]};
    assign out_word_o       = {word_mem[head_nx], word_mem[head]};
    assign out_rs0_o        = {rs0_mem[head_nx], rs0_mem[head]};
    assign out_rs1_o        = {rs1_mem[head_nx], rs1_mem[head]};
    assign out_rd_o         = {rd_mem[head_nx], rd_mem[head]};
    assign out_pred_taken_o = {taken_mem[head_nx], taken_mem[head]};

endmodule

/* verilog/isa_pkg.sv */
package isa_pkg;

    typedef logic [31:0] inst_word_t;

    typedef logic [4:0] reg_idx_t;

    // register-use class from opcode bits 31:28
    typedef enum logic [3:0] {
        CLS_RRW = 4'd0,
        CLS_RW  = 4'd1,
        CLS_RR  = 4'd2,
        CLS_BL  = 4'd3,
        CLS_W   = 4'd4,
        CLS_I   = 4'd15
    } reg_class_e;

    // bl writes the return address here
    localparam reg_idx_t LINK_REG = 5'd1;

endpackage

/* verilog/next_pc_predictor.sv */
`timescale 1ns/1ps
`include "fe_cfg.svh"

module next_pc_predictor (
    input  logic        clk,
    input  logic        rst_i,
    input  logic        pc_take_i,
    input  logic        flush_i,
    input  fe_pkg::pc_t flush_pc_i,
    input  logic        upd_valid_i,
    input  fe_pkg::pc_t upd_pc_i,
    input  fe_pkg::pc_t upd_target_i,
    input  logic        upd_taken_i,
    output fe_pkg::pc_t fetch_pc_o,
    output fe_pkg::pc_t pred_pc_o,
    output logic [1:0]  pred_mask_o,
    output logic        pred_taken_o,
    output fe_pkg::pc_t pred_target_o
);
    localparam int IDX_W = $clog2(`FE_BTB_ENTRIES);
    localparam int TAG_W = 29 - IDX_W;

    logic [`FE_BTB_ENTRIES-1:0] btb_valid;
    logic [TAG_W-1:0]           btb_tag    [`FE_BTB_ENTRIES];
    logic                       btb_slot   [`FE_BTB_ENTRIES];
    fe_pkg::pc_t                btb_target [`FE_BTB_ENTRIES];

    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] upd_idx;
    logic             hit;
    logic             taken;
    logic [1:0]       mask;
    fe_pkg::pc_t      next_pc;

    assign rd_idx  = fetch_pc_o[IDX_W+2:3];
    assign upd_idx = upd_pc_i[IDX_W+2:3];
    assign hit     = btb_valid[rd_idx] && btb_tag[rd_idx] == fetch_pc_o[31:IDX_W+3];

    // a slot 0 branch is not fetched when entering at slot 1
    assign taken   = hit && (btb_slot[rd_idx] || !fetch_pc_o[2]);
    assign mask    = {!(taken && !btb_slot[rd_idx]), !fetch_pc_o[2]};
    assign next_pc = taken ? btb_target[rd_idx] : {fetch_pc_o[31:3], 3'b000} + 32'd8;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            fetch_pc_o <= `FE_RESET_PC;
        end else if (flush_i) begin
            fetch_pc_o <= flush_pc_i;
        end else if (pc_take_i) begin
            fetch_pc_o <= next_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            btb_valid <= '0;
        end else if (upd_valid_i) begin
            if (upd_taken_i) begin
                btb_valid[upd_idx] <= 1'b1;
            end else if (btb_tag[upd_idx] == upd_pc_i[31:IDX_W+3]) begin
                btb_valid[upd_idx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (upd_valid_i && upd_taken_i) begin
            btb_tag[upd_idx]    <= upd_pc_i[31:IDX_W+3];
            btb_slot[upd_idx]   <= upd_pc_i[2];
            btb_target[upd_idx] <= upd_target_i;
        end
    end

    // prediction travels with the pair until the words return
    always_ff @(posedge clk) begin
        if (pc_take_i) begin
            pred_pc_o     <= fetch_pc_o;
            pred_mask_o   <= mask;
            pred_taken_o  <= taken;
            pred_target_o <= btb_target[rd_idx];
        end
    end

endmodule
